// File: fetch_core.f
+incdir+hw
hw/fetch_pkg.sv
hw/seq_num_gen.sv
hw/fetch_unit.sv
hw/fetch_top.sv
tests/fetch_top_tb.sv

// File: hw/fetch_pkg.sv
/*
 * Fetch stage types
 * Vector typedefs shared by the fetch RTL and its testbench
 */

`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

  // --------------------
  // Datapath
  // --------------------

  // Byte address or PC
  typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;
  // Raw instruction word
  typedef logic [`FETCH_INST_BITS-1:0] inst_t;

  // --------------------
  // Sequence numbers and counters
  // --------------------

  typedef logic [`FETCH_SEQ_BITS-1:0] seq_num_t;
  // One extra bit so a full pool is representable
  typedef logic [`FETCH_SEQ_BITS:0] seq_cnt_t;
  // 0 to reclaim width inclusive
  typedef logic [$clog2(`FETCH_RECLAIM_WIDTH+1)-1:0] reclaim_cnt_t;
  // 0 to in-flight limit inclusive
  typedef logic [$clog2(`FETCH_MAX_IN_FLIGHT+1)-1:0] flight_cnt_t;

endpackage

`default_nettype wire

// File: hw/fetch_settings.svh
/*
 * Fetch stage settings
 * Reset address, datapath widths, sequence pool size and flow limits
 */

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address after reset
`define FETCH_RST_ADDR 32'h200

// Datapath widths
`define FETCH_ADDR_BITS 32
`define FETCH_INST_BITS 32

// Sequence pool of 2**3 = 8 numbers
`define FETCH_SEQ_BITS 3

// Memory requests accepted but not yet answered
`define FETCH_MAX_IN_FLIGHT 4
// Most retirements reported per cycle
`define FETCH_RECLAIM_WIDTH 2

`endif

// File: hw/fetch_top.sv
/*
 * Fetch stage top level
 * Memory, decode and commit ports of the fetch unit
 */

`default_nettype none

`include "fetch_settings.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // --------------------
  // Instruction memory
  // --------------------

  output logic         mem_req_val,
  input  logic         mem_req_rdy,
  output addr_t        mem_req_addr,

  input  logic         mem_resp_val,
  output logic         mem_resp_rdy,
  input  addr_t        mem_resp_addr,
  input  inst_t        mem_resp_data,

  // --------------------
  // Decode stage
  // --------------------

  output logic         dec_val,
  input  logic         dec_rdy,
  output addr_t        dec_pc,
  output inst_t        dec_inst,
  output seq_num_t     dec_seq_num,

  // --------------------
  // Commit
  // --------------------

  // Oldest numbers retired this cycle
  input  reclaim_cnt_t commit_cnt
);

  // Single fetch pipe
  fetch_unit u_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_addr  (mem_req_addr),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_addr (mem_resp_addr),
    .mem_resp_data (mem_resp_data),
    .dec_val       (dec_val),
    .dec_rdy       (dec_rdy),
    .dec_pc        (dec_pc),
    .dec_inst      (dec_inst),
    .dec_seq_num   (dec_seq_num),
    .commit_cnt    (commit_cnt)
  );

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
/*
 * Fetch unit
 * Streams sequential reads under an in-flight limit and pairs each
 * returned word with a fresh sequence number for decode
 */

`default_nettype none

`include "fetch_settings.svh"

module fetch_unit
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // Memory request
  output logic         mem_req_val,
  input  logic         mem_req_rdy,
  output addr_t        mem_req_addr,

  // Memory response, in request order
  input  logic         mem_resp_val,
  output logic         mem_resp_rdy,
  input  addr_t        mem_resp_addr,
  input  inst_t        mem_resp_data,

  // Decode
  output logic         dec_val,
  input  logic         dec_rdy,
  output addr_t        dec_pc,
  output inst_t        dec_inst,
  output seq_num_t     dec_seq_num,

  // Commit notification
  input  reclaim_cnt_t commit_cnt
);

  localparam addr_t       rst_addr      = addr_t'(`FETCH_RST_ADDR);
  localparam flight_cnt_t max_in_flight = flight_cnt_t'(`FETCH_MAX_IN_FLIGHT);
  // Fixed-size instructions only
  localparam addr_t       inst_bytes    = addr_t'(4);

  logic req_xfer;
  logic resp_xfer;

  always_comb begin
    req_xfer  = mem_req_val  & mem_req_rdy;
    resp_xfer = mem_resp_val & mem_resp_rdy;
  end

  // --------------------
  // In-flight tracking
  // --------------------

  flight_cnt_t flight_cnt;
  flight_cnt_t flight_cnt_next;

  always_comb begin
    flight_cnt_next = flight_cnt;
    // Request and response in one cycle cancel out
    if (req_xfer && !resp_xfer) begin
      flight_cnt_next = flight_cnt + flight_cnt_t'(1);
    end else if (resp_xfer && !req_xfer) begin
      flight_cnt_next = flight_cnt - flight_cnt_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flight_cnt <= '0;
    end else begin
      flight_cnt <= flight_cnt_next;
    end
  end

  // --------------------
  // Request address
  // --------------------

  addr_t req_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_addr <= rst_addr;
    end else if (req_xfer) begin
      // Next sequential word
      req_addr <= req_addr + inst_bytes;
    end
  end

  always_comb begin
    // Keep issuing while below the limit
    mem_req_val  = (flight_cnt < max_in_flight);
    mem_req_addr = req_addr;
  end

  // --------------------
  // Response to decode
  // --------------------

  logic     alloc_val;
  logic     alloc_rdy;
  seq_num_t alloc_seq_num;

  always_comb begin
    // Zero-cycle path, a free number is needed on both sides
    dec_val      = mem_resp_val & alloc_val;
    mem_resp_rdy = dec_rdy & alloc_val;
    dec_pc       = mem_resp_addr;
    dec_inst     = mem_resp_data;
    dec_seq_num  = alloc_seq_num;

    // alloc_val is already folded in by the allocator
    alloc_rdy    = mem_resp_val & dec_rdy;
  end

  seq_num_gen u_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .alloc_rdy     (alloc_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .commit_cnt    (commit_cnt)
  );

endmodule

`default_nettype wire

// File: hw/seq_num_gen.sv
/*
 * Sequence number allocator
 * Circular pool handing out numbers in order and reclaiming
 * the oldest outstanding ones, several per cycle
 */

`default_nettype none

`include "fetch_settings.svh"

module seq_num_gen
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // Allocation handshake with the fetch unit
  input  logic         alloc_rdy,
  output logic         alloc_val,
  output seq_num_t     alloc_seq_num,

  // Retirements this cycle, oldest first
  input  reclaim_cnt_t commit_cnt
);

  // Number of entries in the pool
  localparam seq_cnt_t pool_size = seq_cnt_t'(1 << `FETCH_SEQ_BITS);

  // --------------------
  // Pool state
  // --------------------

  // Next number to hand out
  seq_num_t head;
  seq_num_t head_next;

  // Numbers handed out and not yet retired
  // oldest outstanding is head - occ_cnt, modulo pool size
  seq_cnt_t occ_cnt;
  seq_cnt_t occ_cnt_next;

  logic     alloc_xfer;

  // --------------------
  // Allocation side
  // --------------------

  always_comb begin
    // Free slot left while not all numbers are out
    alloc_val     = (occ_cnt < pool_size);
    alloc_seq_num = head;
    alloc_xfer    = alloc_val & alloc_rdy;
  end

  // --------------------
  // Next state
  // --------------------

  always_comb begin
    // Head wraps on its own at the pool boundary
    head_next = head;
    if (alloc_xfer) begin
      head_next = head + seq_num_t'(1);
    end

    // Up by one on allocation, down by the retired count
    // commit never exceeds what is allocated, so no underflow
    occ_cnt_next = occ_cnt
                 + seq_cnt_t'(alloc_xfer)
                 - seq_cnt_t'(commit_cnt);
  end

  // --------------------
  // Registers
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head    <= '0;
      occ_cnt <= '0;
    end else begin
      head    <= head_next;
      // Freed numbers become usable the cycle after commit
      occ_cnt <= occ_cnt_next;
    end
  end

endmodule

`default_nettype wire

// File: tests/fetch_cases.txt
// Fetch testbench cases, all values hex
// Part 1: instruction table, one word per address from 0x200 to 0x23c
00000013
00100093
00200113
00308193
00410213
005182b3
40208333
0062f3b3
00739463
0073e433
008444b3
00949513
00a55593
00b5a623
00c62683
fe069ae3
// Part 2: one row per test
// test  count  mem_stall  dec_stall  commit_mode
// stalls are chances out of 16
// commit 0 one per cycle, 1 in pairs, 2 hold until the pool is full
1 30 4 0 0
2 30 8 8 0
3 30 4 0 1
4 30 6 5 1
5 1c 2 0 2
6 20 e 2 0
// End row
0 0 0 0 0

// File: tests/fetch_top_tb.sv
/*
 * Fetch stage testbench
 * Memory model with random stalls, decode sink and commit driver,
 * rows taken from the cases file, one reset per test
 */

`default_nettype none

`include "fetch_settings.svh"

module fetch_top_tb
  import fetch_pkg::*;
();

  localparam int timeout_cycles = 2000;
  localparam int pool_size      = 1 << `FETCH_SEQ_BITS;
  localparam int max_in_flight  = `FETCH_MAX_IN_FLIGHT;
  // 16 table words, six rows of five, one end row
  localparam int case_words     = 51;
  localparam int row_base       = 16;

  // --------------------
  // DUT
  // --------------------

  logic         clk;
  logic         rst;
  logic         mem_req_val;
  logic         mem_req_rdy;
  addr_t        mem_req_addr;
  logic         mem_resp_val;
  logic         mem_resp_rdy;
  addr_t        mem_resp_addr;
  inst_t        mem_resp_data;
  logic         dec_val;
  logic         dec_rdy;
  addr_t        dec_pc;
  inst_t        dec_inst;
  seq_num_t     dec_seq_num;
  reclaim_cnt_t commit_cnt;

  fetch_top u_fetch_top (
    .clk           (clk),
    .rst           (rst),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_addr  (mem_req_addr),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_addr (mem_resp_addr),
    .mem_resp_data (mem_resp_data),
    .dec_val       (dec_val),
    .dec_rdy       (dec_rdy),
    .dec_pc        (dec_pc),
    .dec_inst      (dec_inst),
    .dec_seq_num   (dec_seq_num),
    .commit_cnt    (commit_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Model state
  // --------------------

  logic [31:0] cases_mem [0:case_words-1];
  logic [31:0] rng;
  // Accepted request addresses, oldest first
  addr_t       mem_queue [$];

  // Reference model
  addr_t       exp_pc;
  addr_t       exp_req_addr;
  seq_num_t    exp_seq;
  int          inflight;
  int          ref_out;
  int          accepted;

  // Current row
  int          mem_chance;
  int          dec_chance;
  int          mode;
  int          full_cycles;

  // Transfers seen in the cycle just sampled
  logic        req_xfer;
  logic        resp_xfer;
  logic        dec_xfer;
  addr_t       req_addr_seen;

  int          test_errors;
  int          pass_cnt;
  int          fail_cnt;

  // xorshift32
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // True with a chance of chance/16
  function automatic logic stall_draw(input int chance);
    rng = next_rand(rng);
    return (int'(rng[3:0]) < chance);
  endfunction

  // Table repeats every 16 words
  function automatic inst_t table_word(input addr_t a);
    return cases_mem[((a - `FETCH_RST_ADDR) >> 2) & 32'hf];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %0t: %s expected %h, got %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  // --------------------
  // Per-cycle tasks
  // --------------------

  // Outputs settle by mid-cycle
  task automatic sample_outputs();
    logic room;
    @(negedge clk);
    room          = (ref_out < pool_size);
    req_xfer      = mem_req_val & mem_req_rdy;
    resp_xfer     = mem_resp_val & mem_resp_rdy;
    dec_xfer      = dec_val & dec_rdy;
    req_addr_seen = mem_req_addr;
    compare_value("mem_req_val", inflight < max_in_flight, mem_req_val);
    compare_value("dec_val", mem_resp_val & room, dec_val);
    compare_value("mem_resp_rdy", dec_rdy & room, mem_resp_rdy);
    if (req_xfer) begin
      compare_value("mem_req_addr", exp_req_addr, mem_req_addr);
    end
    if (dec_xfer) begin
      compare_value("dec_pc", exp_pc, dec_pc);
      compare_value("dec_inst", table_word(exp_pc), dec_inst);
      compare_value("dec_seq_num", exp_seq, dec_seq_num);
    end
  endtask

  // Memory, decode and commit for the coming cycle
  task automatic drive_inputs();
    mem_req_rdy = !stall_draw(mem_chance / 4);
    if (!mem_resp_val && mem_queue.size() > 0 && !stall_draw(mem_chance)) begin
      mem_resp_val  = 1'b1;
      mem_resp_addr = mem_queue[0];
      mem_resp_data = table_word(mem_queue[0]);
    end
    dec_rdy = !stall_draw(dec_chance);

    commit_cnt = '0;
    case (mode)
      0: if (ref_out >= 1) commit_cnt = reclaim_cnt_t'(1);
      1: if (ref_out >= 2) commit_cnt = reclaim_cnt_t'(2);
      default: begin
        // Hold a full pool a while, release two once a response waits
        if (ref_out == pool_size) begin
          full_cycles++;
          if (full_cycles >= 6 && mem_resp_val) begin
            commit_cnt  = reclaim_cnt_t'(2);
            full_cycles = 0;
          end
        end
      end
    endcase
  endtask

  // Apply the transfers of the edge just passed
  task automatic advance_model();
    @(posedge clk);
    #2;
    if (req_xfer) begin
      mem_queue.push_back(req_addr_seen);
      exp_req_addr = exp_req_addr + 4;
      inflight++;
    end
    if (resp_xfer) begin
      void'(mem_queue.pop_front());
      mem_resp_val  = 1'b0;
      mem_resp_addr = '0;
      mem_resp_data = '0;
      inflight--;
    end
    if (dec_xfer) begin
      exp_pc = exp_pc + 4;
      exp_seq++;
      ref_out++;
      accepted++;
    end
    ref_out = ref_out - int'(commit_cnt);
    drive_inputs();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst           = 1'b1;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_addr = '0;
    mem_resp_data = '0;
    dec_rdy       = 1'b0;
    commit_cnt    = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    mem_queue.delete();
    exp_pc       = `FETCH_RST_ADDR;
    exp_req_addr = `FETCH_RST_ADDR;
    exp_seq      = '0;
    inflight     = 0;
    ref_out      = 0;
    accepted     = 0;
    full_cycles  = 0;
    req_xfer     = 1'b0;
    resp_xfer    = 1'b0;
    dec_xfer     = 1'b0;
    test_errors  = 0;
  endtask

  // --------------------
  // Test sequence
  // --------------------

  task automatic run_test(input int row);
    int test_num;
    int count;
    int cycles;
    test_num   = int'(cases_mem[row]);
    count      = int'(cases_mem[row+1]);
    mem_chance = int'(cases_mem[row+2]);
    dec_chance = int'(cases_mem[row+3]);
    mode       = int'(cases_mem[row+4]);
    apply_reset();
    drive_inputs();
    cycles = 0;
    while (accepted < count && cycles < timeout_cycles) begin
      sample_outputs();
      advance_model();
      cycles++;
    end
    if (accepted < count) begin
      $display("Test %0d timed out after %0d cycles, %0d of %0d instructions decoded",
               test_num, cycles, accepted, count);
      test_errors++;
    end
    if (test_errors == 0) begin
      pass_cnt++;
      $display("Test %0d PASS: commit mode %0d, %0d instructions in %0d cycles",
               test_num, mode, accepted, cycles);
    end else begin
      fail_cnt++;
      $display("Test %0d FAIL: %0d errors", test_num, test_errors);
    end
  endtask

  initial begin
    int row;
    rst           = 1'b1;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_addr = '0;
    mem_resp_data = '0;
    dec_rdy       = 1'b0;
    commit_cnt    = '0;
    rng           = 32'd6;
    pass_cnt      = 0;
    fail_cnt      = 0;
    for (int i = 0; i < case_words; i++) begin
      cases_mem[i] = '0;
    end
    $readmemh("tests/fetch_cases.txt", cases_mem);

    // End row has test number zero
    row = row_base;
    while (row + 4 < case_words && cases_mem[row] != 32'h0) begin
      run_test(row);
      row = row + 5;
    end

    $display("Passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
